// ==== id_stage.f ====
+incdir+design
design/isa_pkg.sv
design/issue_pkg.sv
design/decode_if.sv
design/decode_latch.sv
design/inst_decoder.sv
design/reg_file.sv
design/operand_fetch.sv
design/branch_resolver.sv
design/id_stage.sv
test/id_stage_sva.sv
test/id_stage_tb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --sv --timing --assert
TOP      := id_stage_tb
FILELIST := id_stage.f
OBJDIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf $(OBJDIR)

// ==== test/id_stage_tb.sv ====
`timescale 1ns/10ps
`include "id_consts.svh"

module id_stage_tb;

  typedef struct {
    string                name;
    logic [`XLEN-1:0]     inst;
    logic [`XLEN-1:0]     pc;
    logic                 es_v;
    logic                 es_ld;
    logic [`REG_AW-1:0]   es_a;
    logic [`XLEN-1:0]     es_d;
    logic                 ms_v;
    logic [`REG_AW-1:0]   ms_a;
    logic [`XLEN-1:0]     ms_d;
    logic                 wb_we;
    logic [`REG_AW-1:0]   wb_a;
    logic [`XLEN-1:0]     wb_d;
    logic                 allow;
    int                   hold;
    issue_pkg::issue_op_e op;
    issue_pkg::dest_t     dest;
    logic [2:0]           en;
    logic [`XLEN-1:0]     v1;
    logic [`XLEN-1:0]     v2;
    logic [`XLEN-1:0]     v3;
    logic                 taken;
    logic                 br;
    logic [`XLEN-1:0]     target;
  } row_t;

  logic clock, reset;
  logic fs_valid_i, wb_we_i, es_valid_i, es_load_i, es_we_i, ms_valid_i, ms_we_i;
  logic es_allowin_i;
  logic [`XLEN-1:0] fs_pc_i, fs_inst_i, wb_wdata_i, es_wdata_i, ms_wdata_i;
  logic [`REG_AW-1:0] wb_waddr_i, es_waddr_i, ms_waddr_i;
  logic ds_allowin_o, br_taken_o, issue_valid_o;
  logic issue_v1_en_o, issue_v2_en_o, issue_v3_en_o;
  logic [`XLEN-1:0] br_target_o, issue_pc_o, issue_v1_o, issue_v2_o, issue_v3_o;
  issue_pkg::issue_op_e issue_op_o;
  issue_pkg::dest_t     issue_dest_o;

  row_t rows[$];
  logic [`XLEN-1:0] model [0:`NUM_REGS-1];
  integer seed = 32'hbe4;
  int errors = 0;
  int failed_tests = 0;
  int limit_cycles = 0;
  logic table_ready = 1'b0;

  id_stage dut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // watchdog sized from the table
  initial begin
    wait (table_ready);
    #(limit_cycles * 8);
    $display("Error: watchdog expired before the tests finished");
    $display("Regression failed");
    $finish;
  end

  function automatic logic [`XLEN-1:0] r_word(input isa_pkg::funct_e fn,
      input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd);
    return {6'h00, rs, rt, rd, 5'h00, fn};
  endfunction

  function automatic logic [`XLEN-1:0] i_word(input logic [5:0] opc,
      input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
    return {opc, rs, rt, imm};
  endfunction

  function automatic row_t blank(input string name, input logic [`XLEN-1:0] inst);
    row_t r;
    r = '{name: "", op: issue_pkg::op_none, default: '0};
    r.name  = name;
    r.inst  = inst;
    r.pc    = 32'h0040_0000 + 32'(rows.size() * 4);
    r.allow = 1'b1;
    r.dest  = `DEST_NONE;
    return r;
  endfunction

  task automatic check_word(input string sig, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic check_op(input string sig, input issue_pkg::issue_op_e got,
                          input issue_pkg::issue_op_e exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s = %s, expected %s", $time, sig, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_dest(input string sig, input issue_pkg::dest_t got,
                            input issue_pkg::dest_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s = %b, expected %b", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s = %b, expected %b", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic check_outputs(input row_t r);
    check_word("issue_pc_o", issue_pc_o, r.pc);
    check_op("issue_op_o", issue_op_o, r.op);
    check_dest("issue_dest_o", issue_dest_o, r.dest);
    check_bit("issue_v1_en_o", issue_v1_en_o, r.en[2]);
    check_bit("issue_v2_en_o", issue_v2_en_o, r.en[1]);
    check_bit("issue_v3_en_o", issue_v3_en_o, r.en[0]);
    if (r.en[2]) check_word("issue_v1_o", issue_v1_o, r.v1);
    if (r.en[1]) check_word("issue_v2_o", issue_v2_o, r.v2);
    if (r.en[0]) check_word("issue_v3_o", issue_v3_o, r.v3);
    check_bit("br_taken_o", br_taken_o, r.taken);
    if (r.br) check_word("br_target_o", br_target_o, r.target);
  endtask

  task automatic apply_row(input row_t r);
    int cnt;
    int err0;
    err0 = errors;
    @(posedge clock);
    fs_valid_i <= 1'b1;
    fs_pc_i    <= r.pc;
    fs_inst_i  <= r.inst;
    es_valid_i <= r.es_v;
    es_we_i    <= r.es_v;
    es_load_i  <= r.es_ld;
    es_waddr_i <= r.es_a;
    es_wdata_i <= r.es_d;
    ms_valid_i <= r.ms_v;
    ms_we_i    <= r.ms_v;
    ms_waddr_i <= r.ms_a;
    ms_wdata_i <= r.ms_d;
    @(posedge clock);
    fs_valid_i   <= 1'b0;
    es_allowin_i <= r.allow;
    // write lands one edge after the read, so only the bypass can supply it
    wb_we_i    <= r.wb_we;
    wb_waddr_i <= r.wb_a;
    wb_wdata_i <= r.wb_d;
    if (r.es_ld) begin
      repeat (r.hold) begin
        @(negedge clock);
        check_bit("issue_valid_o", issue_valid_o, 1'b0);
        check_bit("ds_allowin_o", ds_allowin_o, 1'b0);
      end
      @(posedge clock);
      es_valid_i <= 1'b0;
      es_load_i  <= 1'b0;
    end
    cnt = 0;
    @(negedge clock);
    while (!issue_valid_o && cnt < 4) begin
      @(negedge clock);
      cnt++;
    end
    if (!issue_valid_o) begin
      $display("Error at %0t ns: %s was never issued", $time, r.name);
      errors++;
    end else begin
      check_outputs(r);
    end
    if (!r.allow) begin
      repeat (r.hold) begin
        @(negedge clock);
        check_bit("issue_valid_o", issue_valid_o, 1'b1);
        check_bit("ds_allowin_o", ds_allowin_o, 1'b0);
        check_outputs(r);
      end
      @(posedge clock);
      es_allowin_i <= 1'b1;
    end
    if (errors == err0) begin
      $display("test %s ok", r.name);
    end else begin
      $display("test %s FAILED", r.name);
      failed_tests++;
    end
  endtask

  task automatic build_table();
    row_t r;
    logic [`XLEN-1:0] d0, d1, d2;
    r = blank("addu", r_word(isa_pkg::fn_addu, 5'd5, 5'd6, 5'd3));
    r.op = issue_pkg::op_addu;
    r.dest = 7'd3;
    r.en = 3'b110;
    r.v1 = model[5];
    r.v2 = model[6];
    rows.push_back(r);
    r = blank("slt_r0", r_word(isa_pkg::fn_slt, 5'd0, 5'd9, 5'd7));
    r.op = issue_pkg::op_slt;
    r.dest = 7'd7;
    r.en = 3'b110;
    r.v1 = '0;
    r.v2 = model[9];
    rows.push_back(r);
    // write-back in the same cycle as the read
    d0 = $random(seed);
    r = blank("or_wb", r_word(isa_pkg::fn_or, 5'd10, 5'd12, 5'd11));
    r.wb_we = 1'b1;
    r.wb_a = 5'd10;
    r.wb_d = d0;
    r.op = issue_pkg::op_or;
    r.dest = 7'd11;
    r.en = 3'b110;
    r.v1 = d0;
    r.v2 = model[12];
    rows.push_back(r);
    model[10] = d0;
    r = blank("addiu", i_word(isa_pkg::opc_addiu, 5'd8, 5'd4, 16'hfff0));
    r.op = issue_pkg::op_addu;
    r.dest = 7'd4;
    r.en = 3'b110;
    r.v1 = model[8];
    r.v2 = 32'hffff_fff0;
    rows.push_back(r);
    r = blank("lw", i_word(isa_pkg::opc_lw, 5'd1, 5'd2, 16'h0010));
    r.op = issue_pkg::op_lw;
    r.dest = 7'd2;
    r.en = 3'b110;
    r.v1 = model[1];
    r.v2 = 32'h0000_0010;
    rows.push_back(r);
    r = blank("lui", i_word(isa_pkg::opc_lui, 5'd0, 5'd12, 16'h1234));
    r.op = issue_pkg::op_lui;
    r.dest = 7'd12;
    r.en = 3'b100;
    r.v1 = 32'h1234_0000;
    rows.push_back(r);
    r = blank("sw", i_word(isa_pkg::opc_sw, 5'd14, 5'd13, 16'h8004));
    r.op = issue_pkg::op_sw;
    r.en = 3'b111;
    r.v1 = model[14];
    r.v2 = 32'hffff_8004;
    r.v3 = model[13];
    rows.push_back(r);
    rows.push_back(blank("unknown", i_word(6'h3f, 5'd3, 5'd4, 16'h5555)));
    // execute beats memory beats write-back
    d0 = $random(seed);
    d1 = $random(seed);
    d2 = $random(seed);
    r = blank("fwd_es", r_word(isa_pkg::fn_xor, 5'd15, 5'd16, 5'd1));
    r.es_v = 1'b1;
    r.es_a = 5'd15;
    r.es_d = d0;
    r.ms_v = 1'b1;
    r.ms_a = 5'd15;
    r.ms_d = d1;
    r.wb_we = 1'b1;
    r.wb_a = 5'd15;
    r.wb_d = d2;
    r.op = issue_pkg::op_xor;
    r.dest = 7'd1;
    r.en = 3'b110;
    r.v1 = d0;
    r.v2 = model[16];
    rows.push_back(r);
    model[15] = d2;
    r.name = "fwd_ms";
    r.pc = r.pc + 32'd4;
    r.es_v = 1'b0;
    r.ms_d = $random(seed);
    r.wb_d = $random(seed);
    r.v1 = r.ms_d;
    rows.push_back(r);
    model[15] = r.wb_d;
    r.name = "fwd_wb";
    r.pc = r.pc + 32'd4;
    r.ms_v = 1'b0;
    r.wb_d = $random(seed);
    r.v1 = r.wb_d;
    rows.push_back(r);
    model[15] = r.wb_d;
    r = blank("load_use", r_word(isa_pkg::fn_addu, 5'd17, 5'd18, 5'd5));
    r.es_v = 1'b1;
    r.es_ld = 1'b1;
    r.es_a = 5'd18;
    r.es_d = $random(seed);
    r.hold = 3;
    r.op = issue_pkg::op_addu;
    r.dest = 7'd5;
    r.en = 3'b110;
    r.v1 = model[17];
    r.v2 = model[18];
    rows.push_back(r);
    r = blank("beq_eq", i_word(isa_pkg::opc_beq, 5'd19, 5'd19, 16'hfffc));
    r.op = issue_pkg::op_beq;
    r.en = 3'b111;
    r.br = 1'b1;
    r.taken = 1'b1;
    r.v1 = model[19];
    r.v2 = model[19];
    r.v3 = 32'hffff_fff0;
    r.target = r.pc + 32'd4 - 32'd16;
    rows.push_back(r);
    r = blank("bne", i_word(isa_pkg::opc_bne, 5'd19, 5'd20, 16'h0010));
    r.op = issue_pkg::op_bne;
    r.en = 3'b111;
    r.br = 1'b1;
    r.taken = (model[19] != model[20]);
    r.v1 = model[19];
    r.v2 = model[20];
    r.v3 = 32'h0000_0040;
    r.target = r.pc + 32'd4 + 32'h40;
    rows.push_back(r);
    r = blank("beq_ne", i_word(isa_pkg::opc_beq, 5'd19, 5'd20, 16'h0010));
    r.op = issue_pkg::op_beq;
    r.en = 3'b111;
    r.br = 1'b1;
    r.taken = (model[19] == model[20]);
    r.v1 = model[19];
    r.v2 = model[20];
    r.v3 = 32'h0000_0040;
    r.target = r.pc + 32'd4 + 32'h40;
    rows.push_back(r);
    r = blank("jal", {6'h03, 26'h012_3456});
    r.pc = 32'h4000_0100;
    r.op = issue_pkg::op_jal;
    r.dest = 7'd31;
    r.en = 3'b001;
    r.br = 1'b1;
    r.taken = 1'b1;
    r.v3 = 32'h0012_3456;
    r.target = {4'h4, 26'h012_3456, 2'b00};
    rows.push_back(r);
    r = blank("jr_fwd", r_word(isa_pkg::fn_jr, 5'd21, 5'd0, 5'd0));
    r.ms_v = 1'b1;
    r.ms_a = 5'd21;
    r.ms_d = {$random(seed)} & 32'hffff_fffc;
    r.op = issue_pkg::op_jr;
    r.en = 3'b001;
    r.br = 1'b1;
    r.taken = 1'b1;
    r.v3 = r.ms_d;
    r.target = r.ms_d;
    rows.push_back(r);
    r = blank("backpress", r_word(isa_pkg::fn_nor, 5'd22, 5'd23, 5'd6));
    r.allow = 1'b0;
    r.hold = 3;
    r.op = issue_pkg::op_nor;
    r.dest = 7'd6;
    r.en = 3'b110;
    r.v1 = model[22];
    r.v2 = model[23];
    rows.push_back(r);
    r = blank("after_bp", r_word(isa_pkg::fn_sltu, 5'd24, 5'd25, 5'd8));
    r.op = issue_pkg::op_sltu;
    r.dest = 7'd8;
    r.en = 3'b110;
    r.v1 = model[24];
    r.v2 = model[25];
    rows.push_back(r);
  endtask

  initial begin
    int max_hold;
    reset = 1'b1;
    fs_valid_i = 1'b0;
    fs_pc_i = '0;
    fs_inst_i = '0;
    wb_we_i = 1'b0;
    wb_waddr_i = '0;
    wb_wdata_i = '0;
    es_valid_i = 1'b0;
    es_load_i = 1'b0;
    es_we_i = 1'b0;
    es_waddr_i = '0;
    es_wdata_i = '0;
    ms_valid_i = 1'b0;
    ms_we_i = 1'b0;
    ms_waddr_i = '0;
    ms_wdata_i = '0;
    es_allowin_i = 1'b1;
    model[0] = '0;
    for (int k = 1; k < `NUM_REGS; k++) model[k] = $random(seed);
    build_table();
    max_hold = 0;
    foreach (rows[k]) begin
      if (rows[k].hold > max_hold) max_hold = rows[k].hold;
    end
    // reset and register preload come on top of the rows
    limit_cycles = rows.size() * (max_hold + 4) + `NUM_REGS + 8;
    table_ready = 1'b1;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    for (int k = 1; k < `NUM_REGS; k++) begin
      @(posedge clock);
      wb_we_i    <= 1'b1;
      wb_waddr_i <= 5'(k);
      wb_wdata_i <= model[k];
    end
    @(posedge clock);
    wb_we_i <= 1'b0;
    foreach (rows[k]) apply_row(rows[k]);
    $display("%0d tests, %0d failed, %0d errors", rows.size(), failed_tests, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== test/id_stage_sva.sv ====
`timescale 1ns/10ps
`include "id_consts.svh"

module id_stage_sva (
  input logic             clock,
  input logic             reset,
  input logic             br_taken_o,
  input logic             issue_valid_o,
  input logic             ds_allowin_o,
  input logic             es_allowin_i,
  input logic [`XLEN-1:0] issue_pc_o
);

  // a taken branch is always an issued one
  taken_needs_valid: assert property (@(posedge clock) disable iff (reset)
    br_taken_o |-> issue_valid_o)
    else $error("br_taken_o high without issue_valid_o");

  allowin_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> ds_allowin_o)
    else $error("ds_allowin_o low right after reset");

  // held under back-pressure
  pc_stable_when_blocked: assert property (@(posedge clock) disable iff (reset)
    (issue_valid_o && !es_allowin_i) |=> $stable(issue_pc_o))
    else $error("issue_pc_o changed while blocked");

endmodule

bind id_stage id_stage_sva u_sva (
  .clock         (clock),
  .reset         (reset),
  .br_taken_o    (br_taken_o),
  .issue_valid_o (issue_valid_o),
  .ds_allowin_o  (ds_allowin_o),
  .es_allowin_i  (es_allowin_i),
  .issue_pc_o    (issue_pc_o)
);

// ==== design/id_stage.sv ====
`timescale 1ns/10ps
`include "id_consts.svh"

module id_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 fs_valid_i,
  input  logic [`XLEN-1:0]     fs_pc_i,
  input  logic [`XLEN-1:0]     fs_inst_i,
  input  logic                 wb_we_i,
  input  logic [`REG_AW-1:0]   wb_waddr_i,
  input  logic [`XLEN-1:0]     wb_wdata_i,
  input  logic                 es_valid_i,
  input  logic                 es_load_i,
  input  logic                 es_we_i,
  input  logic [`REG_AW-1:0]   es_waddr_i,
  input  logic [`XLEN-1:0]     es_wdata_i,
  input  logic                 ms_valid_i,
  input  logic                 ms_we_i,
  input  logic [`REG_AW-1:0]   ms_waddr_i,
  input  logic [`XLEN-1:0]     ms_wdata_i,
  input  logic                 es_allowin_i,
  output logic                 ds_allowin_o,
  output logic                 br_taken_o,
  output logic [`XLEN-1:0]     br_target_o,
  output logic                 issue_valid_o,
  output logic [`XLEN-1:0]     issue_pc_o,
  output issue_pkg::issue_op_e issue_op_o,
  output issue_pkg::dest_t     issue_dest_o,
  output logic                 issue_v1_en_o,
  output logic [`XLEN-1:0]     issue_v1_o,
  output logic                 issue_v2_en_o,
  output logic [`XLEN-1:0]     issue_v2_o,
  output logic                 issue_v3_en_o,
  output logic [`XLEN-1:0]     issue_v3_o
);

  logic             ds_valid;
  logic             load_stall;
  logic [`XLEN-1:0] ds_pc;
  logic [`XLEN-1:0] ds_inst;

  decode_if dec_bus ();

  decode_latch u_decode_latch (
    .clock        (clock),
    .reset        (reset),
    .fs_valid_i   (fs_valid_i),
    .fs_pc_i      (fs_pc_i),
    .fs_inst_i    (fs_inst_i),
    .es_allowin_i (es_allowin_i),
    .load_stall_i (load_stall),
    .ds_allowin_o (ds_allowin_o),
    .ds_valid_o   (ds_valid),
    .ds_pc_o      (ds_pc),
    .ds_inst_o    (ds_inst)
  );

  inst_decoder u_inst_decoder (
    .ds_inst_i (ds_inst),
    .ds_pc_i   (ds_pc),
    .dec       (dec_bus.producer)
  );

  operand_fetch u_operand_fetch (
    .clock        (clock),
    .dec          (dec_bus.consumer),
    .ds_valid_i   (ds_valid),
    .wb_we_i      (wb_we_i),
    .wb_waddr_i   (wb_waddr_i),
    .wb_wdata_i   (wb_wdata_i),
    .es_valid_i   (es_valid_i),
    .es_load_i    (es_load_i),
    .es_we_i      (es_we_i),
    .es_waddr_i   (es_waddr_i),
    .es_wdata_i   (es_wdata_i),
    .ms_valid_i   (ms_valid_i),
    .ms_we_i      (ms_we_i),
    .ms_waddr_i   (ms_waddr_i),
    .ms_wdata_i   (ms_wdata_i),
    .load_stall_o (load_stall),
    .v1_en_o      (issue_v1_en_o),
    .v1_o         (issue_v1_o),
    .v2_en_o      (issue_v2_en_o),
    .v2_o         (issue_v2_o),
    .v3_en_o      (issue_v3_en_o),
    .v3_o         (issue_v3_o)
  );

  branch_resolver u_branch_resolver (
    .dec           (dec_bus.consumer),
    .ds_pc_i       (ds_pc),
    .issue_valid_i (issue_valid_o),
    .v1_i          (issue_v1_o),
    .v2_i          (issue_v2_o),
    .v3_i          (issue_v3_o),
    .br_taken_o    (br_taken_o),
    .br_target_o   (br_target_o)
  );

  assign issue_valid_o = ds_valid && !load_stall;
  assign issue_pc_o    = ds_pc;
  assign issue_op_o    = dec_bus.op;
  assign issue_dest_o  = dec_bus.dest;

endmodule

// ==== design/branch_resolver.sv ====
`timescale 1ns/10ps
`include "id_consts.svh"

module branch_resolver (
  decode_if.consumer       dec,
  input  logic [`XLEN-1:0] ds_pc_i,
  input  logic             issue_valid_i,
  input  logic [`XLEN-1:0] v1_i,
  input  logic [`XLEN-1:0] v2_i,
  input  logic [`XLEN-1:0] v3_i,
  output logic             br_taken_o,
  output logic [`XLEN-1:0] br_target_o
);

  logic             ops_equal;
  logic             taken;
  logic [`XLEN-1:0] pc_seq;

  assign ops_equal = (v1_i == v2_i);
  assign pc_seq    = ds_pc_i + `PC_STEP;

  always_comb begin
    taken       = 1'b0;
    br_target_o = pc_seq;
    case (dec.br_kind)
      issue_pkg::br_beq: begin
        taken       = ops_equal;
        br_target_o = pc_seq + v3_i;
      end
      issue_pkg::br_bne: begin
        taken       = !ops_equal;
        br_target_o = pc_seq + v3_i;
      end
      issue_pkg::br_jal: begin
        // region of the delay slot, word index below
        taken       = 1'b1;
        br_target_o = {pc_seq[31:28], v3_i[25:0], 2'b00};
      end
      issue_pkg::br_jr: begin
        taken       = 1'b1;
        br_target_o = v3_i;
      end
      default: ;
    endcase
  end

  assign br_taken_o = issue_valid_i && taken;

endmodule

// ==== design/operand_fetch.sv ====
`timescale 1ns/10ps
`include "id_consts.svh"

module operand_fetch (
  input  logic               clock,
  decode_if.consumer         dec,
  input  logic               ds_valid_i,
  input  logic               wb_we_i,
  input  logic [`REG_AW-1:0] wb_waddr_i,
  input  logic [`XLEN-1:0]   wb_wdata_i,
  input  logic               es_valid_i,
  input  logic               es_load_i,
  input  logic               es_we_i,
  input  logic [`REG_AW-1:0] es_waddr_i,
  input  logic [`XLEN-1:0]   es_wdata_i,
  input  logic               ms_valid_i,
  input  logic               ms_we_i,
  input  logic [`REG_AW-1:0] ms_waddr_i,
  input  logic [`XLEN-1:0]   ms_wdata_i,
  output logic               load_stall_o,
  output logic               v1_en_o,
  output logic [`XLEN-1:0]   v1_o,
  output logic               v2_en_o,
  output logic [`XLEN-1:0]   v2_o,
  output logic               v3_en_o,
  output logic [`XLEN-1:0]   v3_o
);

  logic [`REG_AW-1:0] raddr0, raddr1;
  logic [`XLEN-1:0]   rdata0, rdata1;
  logic [`XLEN-1:0]   src0, src1;
  logic use0, use1;
  logic es_hit0, es_hit1, ms_hit0, ms_hit1, wb_hit0, wb_hit1;
  logic ld_hit0, ld_hit1;

  // register 0 never matches a producer
  function automatic logic hit(input logic valid, input logic we,
                               input logic [`REG_AW-1:0] waddr,
                               input logic [`REG_AW-1:0] raddr);
    return valid && we && (waddr == raddr) && (raddr != '0);
  endfunction

  // port 0 feeds v1, port 1 feeds v2 and v3
  assign raddr0 = dec.rs_addr;
  assign raddr1 = (dec.v3_sel == issue_pkg::sel_rs) ? dec.rs_addr : dec.rt_addr;

  reg_file u_reg_file (
    .clock    (clock),
    .raddr0_i (raddr0),
    .raddr1_i (raddr1),
    .rdata0_o (rdata0),
    .rdata1_o (rdata1),
    .we_i     (wb_we_i),
    .waddr_i  (wb_waddr_i),
    .wdata_i  (wb_wdata_i)
  );

  assign use0 = (dec.v1_sel == issue_pkg::sel_rs);
  assign use1 = (dec.v2_sel == issue_pkg::sel_rt) ||
                (dec.v3_sel == issue_pkg::sel_rs) ||
                (dec.v3_sel == issue_pkg::sel_rt);

  assign es_hit0 = hit(es_valid_i, es_we_i, es_waddr_i, raddr0);
  assign es_hit1 = hit(es_valid_i, es_we_i, es_waddr_i, raddr1);
  assign ms_hit0 = hit(ms_valid_i, ms_we_i, ms_waddr_i, raddr0);
  assign ms_hit1 = hit(ms_valid_i, ms_we_i, ms_waddr_i, raddr1);
  assign wb_hit0 = hit(1'b1, wb_we_i, wb_waddr_i, raddr0);
  assign wb_hit1 = hit(1'b1, wb_we_i, wb_waddr_i, raddr1);

  assign ld_hit0 = es_hit0 && es_load_i;
  assign ld_hit1 = es_hit1 && es_load_i;

  assign load_stall_o = ds_valid_i && ((use0 && ld_hit0) || (use1 && ld_hit1));

  // load result not ready yet, hold a zero
  assign src0 = ld_hit0 ? '0         :
                es_hit0 ? es_wdata_i :
                ms_hit0 ? ms_wdata_i :
                wb_hit0 ? wb_wdata_i : rdata0;
  assign src1 = ld_hit1 ? '0         :
                es_hit1 ? es_wdata_i :
                ms_hit1 ? ms_wdata_i :
                wb_hit1 ? wb_wdata_i : rdata1;

  assign v1_en_o = (dec.v1_sel != issue_pkg::sel_none);
  assign v2_en_o = (dec.v2_sel != issue_pkg::sel_none);
  assign v3_en_o = (dec.v3_sel != issue_pkg::sel_none);

  assign v1_o = use0 ? src0 :
                (dec.v1_sel == issue_pkg::sel_imm) ? dec.v1_imm : '0;
  assign v2_o = (dec.v2_sel == issue_pkg::sel_rt) ? src1 :
                (dec.v2_sel == issue_pkg::sel_imm) ? dec.v2_imm : '0;
  assign v3_o = (dec.v3_sel == issue_pkg::sel_rs || dec.v3_sel == issue_pkg::sel_rt) ? src1 :
                (dec.v3_sel == issue_pkg::sel_imm) ? dec.v3_imm : '0;

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/10ps
`include "id_consts.svh"

module reg_file (
  input  logic              clock,
  input  logic [`REG_AW-1:0] raddr0_i,
  input  logic [`REG_AW-1:0] raddr1_i,
  output logic [`XLEN-1:0]   rdata0_o,
  output logic [`XLEN-1:0]   rdata1_o,
  input  logic              we_i,
  input  logic [`REG_AW-1:0] waddr_i,
  input  logic [`XLEN-1:0]   wdata_i
);

  // register 0 has no storage
  logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

  always_ff @(posedge clock) begin
    if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];

endmodule

// ==== design/inst_decoder.sv ====
`timescale 1ns/10ps
`include "id_consts.svh"

module inst_decoder (
  input  isa_pkg::inst_word_u ds_inst_i,
  input  logic [`XLEN-1:0]    ds_pc_i,
  decode_if.producer          dec
);

  isa_pkg::r_fmt_t r;
  isa_pkg::i_fmt_t i;
  logic pc_ok, is_special, r_alu;
  logic inst_addu, inst_subu, inst_slt, inst_sltu;
  logic inst_and, inst_or, inst_xor, inst_nor;
  logic inst_addiu, inst_lui, inst_lw, inst_sw;
  logic inst_beq, inst_bne, inst_jal, inst_jr;

  assign r = ds_inst_i.r;
  assign i = ds_inst_i.i;

  // a misaligned fetch issues as a bubble
  assign pc_ok      = (ds_pc_i[1:0] == 2'b00);
  assign is_special = pc_ok && (r.opcode == isa_pkg::opc_special);

  assign inst_addu  = is_special && (r.funct == isa_pkg::fn_addu);
  assign inst_subu  = is_special && (r.funct == isa_pkg::fn_subu);
  assign inst_slt   = is_special && (r.funct == isa_pkg::fn_slt);
  assign inst_sltu  = is_special && (r.funct == isa_pkg::fn_sltu);
  assign inst_and   = is_special && (r.funct == isa_pkg::fn_and);
  assign inst_or    = is_special && (r.funct == isa_pkg::fn_or);
  assign inst_xor   = is_special && (r.funct == isa_pkg::fn_xor);
  assign inst_nor   = is_special && (r.funct == isa_pkg::fn_nor);
  assign inst_jr    = is_special && (r.funct == isa_pkg::fn_jr) &&
                      (r.rt == '0) && (r.rd == '0);
  assign inst_addiu = pc_ok && (i.opcode == isa_pkg::opc_addiu);
  assign inst_lui   = pc_ok && (i.opcode == isa_pkg::opc_lui) && (i.rs == '0);
  assign inst_lw    = pc_ok && (i.opcode == isa_pkg::opc_lw);
  assign inst_sw    = pc_ok && (i.opcode == isa_pkg::opc_sw);
  assign inst_beq   = pc_ok && (i.opcode == isa_pkg::opc_beq);
  assign inst_bne   = pc_ok && (i.opcode == isa_pkg::opc_bne);
  assign inst_jal   = pc_ok && (i.opcode == isa_pkg::opc_jal);

  assign r_alu = inst_addu | inst_subu | inst_slt | inst_sltu |
                 inst_and  | inst_or   | inst_xor | inst_nor;

  always_comb begin
    dec.op = issue_pkg::op_none;
    if (inst_addu)  dec.op = issue_pkg::op_addu;
    if (inst_subu)  dec.op = issue_pkg::op_subu;
    if (inst_slt)   dec.op = issue_pkg::op_slt;
    if (inst_sltu)  dec.op = issue_pkg::op_sltu;
    if (inst_and)   dec.op = issue_pkg::op_and;
    if (inst_or)    dec.op = issue_pkg::op_or;
    if (inst_xor)   dec.op = issue_pkg::op_xor;
    if (inst_nor)   dec.op = issue_pkg::op_nor;
    if (inst_addiu) dec.op = issue_pkg::op_addiu;
    if (inst_lui)   dec.op = issue_pkg::op_lui;
    if (inst_lw)    dec.op = issue_pkg::op_lw;
    if (inst_sw)    dec.op = issue_pkg::op_sw;
    if (inst_beq)   dec.op = issue_pkg::op_beq;
    if (inst_bne)   dec.op = issue_pkg::op_bne;
    if (inst_jal)   dec.op = issue_pkg::op_jal;
    if (inst_jr)    dec.op = issue_pkg::op_jr;
  end

  assign dec.v1_sel = (r_alu | inst_addiu | inst_lw | inst_sw | inst_beq | inst_bne) ?
                      issue_pkg::sel_rs :
                      inst_lui ? issue_pkg::sel_imm : issue_pkg::sel_none;
  assign dec.v2_sel = (r_alu | inst_beq | inst_bne) ? issue_pkg::sel_rt :
                      (inst_addiu | inst_lw | inst_sw) ? issue_pkg::sel_imm :
                      issue_pkg::sel_none;
  assign dec.v3_sel = inst_jr ? issue_pkg::sel_rs :
                      inst_sw ? issue_pkg::sel_rt :
                      (inst_beq | inst_bne | inst_jal) ? issue_pkg::sel_imm :
                      issue_pkg::sel_none;

  assign dec.rs_addr = i.rs;
  assign dec.rt_addr = i.rt;

  assign dec.v1_imm = {i.imm, 16'h0};
  assign dec.v2_imm = {{16{i.imm[15]}}, i.imm};
  // jump index or word offset
  assign dec.v3_imm = inst_jal ? {6'h0, ds_inst_i[25:0]} :
                      {{14{i.imm[15]}}, i.imm, 2'b00};

  assign dec.dest = inst_jal ? 7'd31 :
                    r_alu ? {2'b00, r.rd} :
                    (inst_addiu | inst_lui | inst_lw) ? {2'b00, i.rt} :
                    `DEST_NONE;

  assign dec.br_kind = inst_beq ? issue_pkg::br_beq :
                       inst_bne ? issue_pkg::br_bne :
                       inst_jal ? issue_pkg::br_jal :
                       inst_jr  ? issue_pkg::br_jr  : issue_pkg::br_none;

endmodule

// ==== design/decode_latch.sv ====
`timescale 1ns/10ps
`include "id_consts.svh"

module decode_latch (
  input  logic             clock,
  input  logic             reset,
  input  logic             fs_valid_i,
  input  logic [`XLEN-1:0] fs_pc_i,
  input  logic [`XLEN-1:0] fs_inst_i,
  input  logic             es_allowin_i,
  input  logic             load_stall_i,
  output logic             ds_allowin_o,
  output logic             ds_valid_o,
  output logic [`XLEN-1:0] ds_pc_o,
  output logic [`XLEN-1:0] ds_inst_o
);

  logic ds_valid_r;

  // empty, or the held instruction leaves this cycle
  assign ds_allowin_o = !ds_valid_r || (!load_stall_i && es_allowin_i);
  assign ds_valid_o   = ds_valid_r;

  always_ff @(posedge clock) begin
    if (reset) begin
      ds_valid_r <= 1'b0;
    end else if (ds_allowin_o) begin
      ds_valid_r <= fs_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    if (fs_valid_i && ds_allowin_o) begin
      ds_pc_o   <= fs_pc_i;
      ds_inst_o <= fs_inst_i;
    end
  end

endmodule

// ==== design/decode_if.sv ====
`timescale 1ns/10ps
`include "id_consts.svh"

interface decode_if;
  issue_pkg::issue_op_e op;
  issue_pkg::dest_t     dest;
  issue_pkg::src_sel_e  v1_sel;
  issue_pkg::src_sel_e  v2_sel;
  issue_pkg::src_sel_e  v3_sel;
  logic [`REG_AW-1:0]   rs_addr;
  logic [`REG_AW-1:0]   rt_addr;
  logic [`XLEN-1:0]     v1_imm;
  logic [`XLEN-1:0]     v2_imm;
  logic [`XLEN-1:0]     v3_imm;
  issue_pkg::br_kind_e  br_kind;

  modport producer (output op, dest, v1_sel, v2_sel, v3_sel, rs_addr, rt_addr,
                    v1_imm, v2_imm, v3_imm, br_kind);
  modport consumer (input op, dest, v1_sel, v2_sel, v3_sel, rs_addr, rt_addr,
                    v1_imm, v2_imm, v3_imm, br_kind);
endinterface

// ==== design/issue_pkg.sv ====
package issue_pkg;

  // internal operation codes handed to execute
  typedef enum logic [7:0] {
    op_none = 8'h00,
    op_lui  = 8'h05,
    op_addu = 8'h19,
    op_subu = 8'h1b,
    op_and  = 8'h1c,
    op_or   = 8'h1d,
    op_xor  = 8'h1e,
    op_nor  = 8'h1f,
    op_slt  = 8'h26,
    op_sltu = 8'h27,
    op_jr   = 8'h2d,
    op_jal  = 8'h2e,
    op_beq  = 8'h30,
    op_bne  = 8'h31,
    op_lw   = 8'h92,
    op_sw   = 8'h9a
  } issue_op_e;

  // addiu uses the same adder code as addu
  localparam issue_op_e op_addiu = op_addu;

  // low bits hold the register number
  typedef logic [6:0] dest_t;

  typedef enum logic [1:0] {
    sel_none,
    sel_rs,
    sel_rt,
    sel_imm
  } src_sel_e;

  typedef enum logic [2:0] {
    br_none,
    br_beq,
    br_bne,
    br_jal,
    br_jr
  } br_kind_e;

endpackage

// ==== design/isa_pkg.sv ====
`include "id_consts.svh"

package isa_pkg;

  // primary opcode field
  typedef enum logic [5:0] {
    opc_special = 6'h00,
    opc_jal     = 6'h03,
    opc_beq     = 6'h04,
    opc_bne     = 6'h05,
    opc_addiu   = 6'h09,
    opc_lui     = 6'h0f,
    opc_lw      = 6'h23,
    opc_sw      = 6'h2b
  } opcode_e;

  // function field of special opcode
  typedef enum logic [5:0] {
    fn_jr   = 6'h08,
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_xor  = 6'h26,
    fn_nor  = 6'h27,
    fn_slt  = 6'h2a,
    fn_sltu = 6'h2b
  } funct_e;

  typedef struct packed {
    opcode_e            opcode;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [`REG_AW-1:0] rd;
    logic [4:0]         sa;
    funct_e             funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_e            opcode;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [15:0]        imm;
  } i_fmt_t;

  // same word seen as register or immediate format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_word_u;

endpackage

// ==== design/id_consts.svh ====
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// data path and pc width
`define XLEN 32

// register file geometry
`define REG_AW 5
`define NUM_REGS 32

// sequential pc increment
`define PC_STEP 32'd4

// destination code for no register write
`define DEST_NONE 7'b1100000

`endif
